// File: noc_cfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// virtual channels per input port
`define NOC_V 4
`define NOC_B 4          // flits per vc buffer
`define NOC_FPAY 32      // flit payload bits

// mesh coordinate widths
`define NOC_XW 3
`define NOC_YW 3

`define NOC_C 2          // traffic classes
`define NOC_MAX_PCK 2    // buffer depth over min packet size of 2
`define NOC_P 5          // router ports incl. local

// output vcs each class may use
`define NOC_CLASS0_VCS 4'b0011
`define NOC_CLASS1_VCS 4'b1100

`endif

// File: noc_pkg.sv
`include "noc_cfg.svh"

package noc_pkg;

    typedef logic [`NOC_V-1:0] vc_mask_t;
    typedef logic [`NOC_P-1:0] port_t;   // one-hot output port
    typedef logic [$clog2(`NOC_C)-1:0] class_t;

    // one-hot port encodings
    localparam port_t PORT_LOCAL = 5'b00001;
    localparam port_t PORT_EAST  = 5'b00010;
    localparam port_t PORT_NORTH = 5'b00100;
    localparam port_t PORT_WEST  = 5'b01000;
    localparam port_t PORT_SOUTH = 5'b10000;

    typedef struct packed {
        logic [`NOC_XW-1:0] x;
        logic [`NOC_YW-1:0] y;
    } router_addr_t;

    typedef struct packed {
        logic                 hdr;
        logic                 tail;
        vc_mask_t             vc;        // one-hot vc of this hop
        logic [`NOC_FPAY-1:0] payload;
    } flit_t;

    // header flit payload layout, user bits on top
    typedef struct packed {
        logic [`NOC_FPAY-$bits(router_addr_t)-$bits(class_t)-1:0] user;
        class_t                                                    cls;
        router_addr_t                                              dest;
    } hdr_payload_t;

    typedef struct packed {
        port_t  port;
        class_t cls;
    } pck_desc_t;

endpackage

// File: fwft_fifo.sv
`timescale 1ns/1ns
`include "noc_cfg.svh"

module fwft_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `NOC_B
) (
    input  logic clk,
    input  logic reset,
    input  logic wr_i,
    input  T     data_i,
    input  logic rd_i,
    output T     data_o,     // head word, valid while not empty
    output logic empty_o,
    output logic full_o
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_i) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_i) rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_i, rd_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or both
            endcase
        end
    end

    assign data_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = (count == CW'(DEPTH));

    // sender holds credits, so these never fire in a correct system
    a_no_wr_full: assert property (@(posedge clk) disable iff (reset) wr_i |-> !full_o)
        else $error("fwft_fifo: write while full");
    a_no_rd_empty: assert property (@(posedge clk) disable iff (reset) rd_i |-> !empty_o)
        else $error("fwft_fifo: read while empty");

endmodule

// File: xy_route_decode.sv
`timescale 1ns/1ns
`include "noc_cfg.svh"

module xy_route_decode (
    input  noc_pkg::flit_t        flit_i,
    input  noc_pkg::router_addr_t current_addr_i,
    output noc_pkg::pck_desc_t    desc_o
);

    noc_pkg::hdr_payload_t hdr;
    noc_pkg::port_t        port;
    logic                  x_gt;
    logic                  x_lt;
    logic                  y_gt;
    logic                  y_lt;

    // payload viewed as header fields
    assign hdr = noc_pkg::hdr_payload_t'(flit_i.payload);

    assign x_gt = (hdr.dest.x > current_addr_i.x);
    assign x_lt = (hdr.dest.x < current_addr_i.x);
    assign y_gt = (hdr.dest.y > current_addr_i.y);
    assign y_lt = (hdr.dest.y < current_addr_i.y);

    // dimension order, x resolved first
    always_comb begin
        if (x_gt) begin
            port = noc_pkg::PORT_EAST;
        end else if (x_lt) begin
            port = noc_pkg::PORT_WEST;
        end else if (y_gt) begin
            port = noc_pkg::PORT_NORTH;
        end else if (y_lt) begin
            port = noc_pkg::PORT_SOUTH;
        end else begin
            port = noc_pkg::PORT_LOCAL;   // arrived
        end
    end

    // class rides along for the ovc mask lookup
    assign desc_o.port = port;
    assign desc_o.cls  = hdr.cls;

endmodule

// File: vc_queue.sv
`timescale 1ns/1ns
`include "noc_cfg.svh"

module vc_queue (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_i,
    input  noc_pkg::flit_t     flit_i,
    input  noc_pkg::pck_desc_t desc_i,
    input  logic               grant_i,
    input  logic               release_i,
    output noc_pkg::flit_t     head_o,
    output logic               request_o,
    output logic               tail_o,
    output noc_pkg::port_t     dest_port_o,
    output noc_pkg::vc_mask_t  candidate_ovcs_o
);

    logic               flit_empty;
    logic               desc_wr;
    logic               desc_empty;
    noc_pkg::pck_desc_t desc_head;

    assign desc_wr = wr_i & flit_i.hdr;   // one descriptor per packet

    fwft_fifo #(.T(noc_pkg::flit_t), .DEPTH(`NOC_B)) i_flit_fifo (
        .clk    (clk),
        .reset  (reset),
        .wr_i   (wr_i),
        .data_i (flit_i),
        .rd_i   (grant_i),
        .data_o (head_o),
        .empty_o(flit_empty),
        .full_o ()
    );

    fwft_fifo #(.T(noc_pkg::pck_desc_t), .DEPTH(`NOC_MAX_PCK)) i_desc_fifo (
        .clk    (clk),
        .reset  (reset),
        .wr_i   (desc_wr),
        .data_i (desc_i),
        .rd_i   (release_i),
        .data_o (desc_head),
        .empty_o(desc_empty),
        .full_o ()
    );

    assign request_o   = !flit_empty;
    assign tail_o      = request_o & head_o.tail;
    assign dest_port_o = desc_empty ? '0 : desc_head.port;

    // class to candidate output vcs
    always_comb begin
        candidate_ovcs_o = '0;
        if (!desc_empty) begin
            case (desc_head.cls)
                noc_pkg::class_t'(0): candidate_ovcs_o = `NOC_CLASS0_VCS;
                noc_pkg::class_t'(1): candidate_ovcs_o = `NOC_CLASS1_VCS;
                default:              candidate_ovcs_o = '0;
            endcase
        end
    end

    a_release_has_desc: assert property (@(posedge clk) disable iff (reset)
        release_i |-> !desc_empty) else $error("vc_queue: release with no packet queued");
    // a header at the head always has its route ready
    a_hdr_grant_desc: assert property (@(posedge clk) disable iff (reset)
        grant_i && head_o.hdr |-> !desc_empty) else $error("vc_queue: header without descriptor");

endmodule

// File: input_port.sv
`timescale 1ns/1ns
`include "noc_cfg.svh"

module input_port (
    input  logic                                clk,
    input  logic                                reset,
    input  noc_pkg::router_addr_t               current_addr_i,
    input  noc_pkg::flit_t                      flit_i,
    input  logic                                flit_we_i,
    input  noc_pkg::vc_mask_t                   ivc_grant_i,     // one-hot
    input  noc_pkg::vc_mask_t                   ivc_release_i,
    input  noc_pkg::vc_mask_t                   assigned_ovc_i,
    output noc_pkg::flit_t                      flit_o,
    output noc_pkg::vc_mask_t                   ivc_request_o,
    output noc_pkg::vc_mask_t                   ivc_tail_o,
    output noc_pkg::port_t    [`NOC_V-1:0]      dest_port_o,
    output noc_pkg::vc_mask_t [`NOC_V-1:0]      candidate_ovcs_o
);

    noc_pkg::pck_desc_t desc_in;
    noc_pkg::vc_mask_t  vc_wr;
    noc_pkg::flit_t     head [`NOC_V];
    noc_pkg::flit_t     granted;

    // route computed as the header arrives
    xy_route_decode i_route (
        .flit_i        (flit_i),
        .current_addr_i(current_addr_i),
        .desc_o        (desc_in)
    );

    assign vc_wr = flit_we_i ? flit_i.vc : '0;   // steer by vc field

    for (genvar v = 0; v < `NOC_V; v++) begin : g_vc
        vc_queue i_vc_queue (
            .clk             (clk),
            .reset           (reset),
            .wr_i            (vc_wr[v]),
            .flit_i          (flit_i),
            .desc_i          (desc_in),
            .grant_i         (ivc_grant_i[v]),
            .release_i       (ivc_release_i[v]),
            .head_o          (head[v]),
            .request_o       (ivc_request_o[v]),
            .tail_o          (ivc_tail_o[v]),
            .dest_port_o     (dest_port_o[v]),
            .candidate_ovcs_o(candidate_ovcs_o[v])
        );
    end

    // granted head, grant is one-hot or idle
    always_comb begin
        granted = '0;
        for (int v = 0; v < `NOC_V; v++) begin
            if (ivc_grant_i[v]) begin
                granted = head[v];
            end
        end
    end

    // vc field rewritten for the next hop
    always_comb begin
        flit_o    = granted;
        flit_o.vc = assigned_ovc_i;
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(ivc_grant_i)) else $error("input_port: grant not one-hot");

    // allocators only see vcs that hold a flit
    a_grant_requested: assert property (@(posedge clk) disable iff (reset)
        (ivc_grant_i & ~ivc_request_o) == '0)
        else $error("input_port: grant to idle vc");

    a_write_onehot: assert property (@(posedge clk) disable iff (reset)
        flit_we_i |-> $onehot(flit_i.vc))
        else $error("input_port: written flit has no single vc");

endmodule

// File: tb_input_port.sv
`timescale 1ns/1ns
`include "noc_cfg.svh"

module tb_input_port;

    localparam int RESET_CYCLES   = 3;
    localparam int TRAFFIC_CYCLES = 2000;
    localparam int DRAIN_CYCLES   = 300;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + TRAFFIC_CYCLES + DRAIN_CYCLES + 10;
    localparam int HERE_X         = 3;   // router under test sits at (3,3)
    localparam int HERE_Y         = 3;

    logic                           clk;
    logic                           reset;
    noc_pkg::router_addr_t          current_addr;
    noc_pkg::flit_t                 flit_in;
    logic                           flit_we;
    noc_pkg::vc_mask_t              grant;
    noc_pkg::vc_mask_t              rel_vec;
    noc_pkg::vc_mask_t              assigned_ovc;
    noc_pkg::flit_t                 flit_out;
    noc_pkg::vc_mask_t              request;
    noc_pkg::vc_mask_t              tail;
    noc_pkg::port_t    [`NOC_V-1:0] dest_port;
    noc_pkg::vc_mask_t [`NOC_V-1:0] cand_ovcs;

    // reference model, one flit queue and one descriptor queue per vc
    noc_pkg::flit_t     flit_q [`NOC_V][$];
    noc_pkg::pck_desc_t desc_q [`NOC_V][$];
    int                 tx_left [`NOC_V];   // body flits still owed by the open packet
    logic [`NOC_V-1:0]  rel_pending;        // tail granted, release not yet sent

    integer         seed;
    int             checks;
    int             errors;
    int             tests;
    int             advance_seen;
    int             errs_before;
    int             n;
    noc_pkg::port_t dirs_seen;

    input_port i_dut (
        .clk             (clk),
        .reset           (reset),
        .current_addr_i  (current_addr),
        .flit_i          (flit_in),
        .flit_we_i       (flit_we),
        .ivc_grant_i     (grant),
        .ivc_release_i   (rel_vec),
        .assigned_ovc_i  (assigned_ovc),
        .flit_o          (flit_out),
        .ivc_request_o   (request),
        .ivc_tail_o      (tail),
        .dest_port_o     (dest_port),
        .candidate_ovcs_o(cand_ovcs)
    );

    always #5 clk = ~clk;

    function automatic int rnd(input int lim);
        return $unsigned($random(seed)) % lim;
    endfunction

    // dimension order routing, x first
    function automatic noc_pkg::port_t xy_expect(input noc_pkg::router_addr_t dest);
        if (dest.x > HERE_X) return 5'b00010;
        if (dest.x < HERE_X) return 5'b01000;
        if (dest.y > HERE_Y) return 5'b00100;
        if (dest.y < HERE_Y) return 5'b10000;
        return 5'b00001;
    endfunction

    function automatic noc_pkg::vc_mask_t class_mask(input noc_pkg::class_t cls);
        return (cls == 0) ? 4'b0011 : 4'b1100;
    endfunction

    // destination drawn per direction so all five ports get traffic
    function automatic noc_pkg::hdr_payload_t random_header();
        noc_pkg::hdr_payload_t hp;
        hp = noc_pkg::hdr_payload_t'($random(seed));
        hp.cls = noc_pkg::class_t'(rnd(`NOC_C));
        hp.dest.x = 3'(HERE_X);
        hp.dest.y = 3'(HERE_Y);
        case (rnd(5))
            1: hp.dest.x = 3'(HERE_X + 1 + rnd(7 - HERE_X));
            2: hp.dest.x = 3'(rnd(HERE_X));
            3: hp.dest.y = 3'(HERE_Y + 1 + rnd(7 - HERE_Y));
            4: hp.dest.y = 3'(rnd(HERE_Y));
            default: ;   // local
        endcase
        return hp;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-16s finished with %0d errors", name, errors - errs_before);
        errs_before = errors;
    endtask

    function automatic bit model_idle();
        for (int v = 0; v < `NOC_V; v++) begin
            if (flit_q[v].size() != 0 || desc_q[v].size() != 0 || tx_left[v] != 0) return 0;
        end
        return 1;
    endfunction

    // sampled mid cycle, inputs and outputs settled
    task automatic check_outputs();
        noc_pkg::vc_mask_t exp_req;
        noc_pkg::vc_mask_t exp_tail;
        noc_pkg::flit_t    exp_flit;
        exp_req  = '0;
        exp_tail = '0;
        for (int v = 0; v < `NOC_V; v++) begin
            if (flit_q[v].size() > 0) begin
                exp_req[v]  = 1'b1;
                exp_tail[v] = flit_q[v][0].tail;
                if (desc_q[v].size() == 0) begin
                    errors++;
                    $display("model error at %0t ns: vc %0d holds flits but no packet", $time, v);
                end else begin
                    compare($sformatf("dest_port_o[%0d]", v), dest_port[v], desc_q[v][0].port);
                    compare($sformatf("candidate_ovcs_o[%0d]", v), cand_ovcs[v],
                            class_mask(desc_q[v][0].cls));
                end
            end
            if (grant[v]) begin
                exp_flit    = flit_q[v][0];
                exp_flit.vc = assigned_ovc;   // next hop vc
                compare("flit_o", flit_out, exp_flit);
            end
        end
        compare("ivc_request_o", request, exp_req);
        compare("ivc_tail_o", tail, exp_tail);
    endtask

    // apply what the DUT will take at the coming edge
    task automatic commit_model();
        noc_pkg::flit_t        f;
        noc_pkg::hdr_payload_t hp;
        noc_pkg::pck_desc_t    d;
        for (int v = 0; v < `NOC_V; v++) begin
            if (grant[v]) begin
                f = flit_q[v].pop_front();
                if (f.tail) rel_pending[v] = 1'b1;
            end
            if (rel_vec[v]) begin
                if (desc_q[v].size() == `NOC_MAX_PCK) advance_seen++;
                void'(desc_q[v].pop_front());
                rel_pending[v] = 1'b0;
            end
            if (flit_we && flit_in.vc[v]) begin
                flit_q[v].push_back(flit_in);
                if (flit_in.hdr) begin
                    hp     = noc_pkg::hdr_payload_t'(flit_in.payload);
                    d.port = xy_expect(hp.dest);
                    d.cls  = hp.cls;
                    dirs_seen |= d.port;
                    desc_q[v].push_back(d);
                end
            end
        end
    endtask

    // picks the next write, grant and releases within the credit limits
    task automatic drive_next(input bit new_pkts);
        noc_pkg::flit_t    f;
        noc_pkg::vc_mask_t elig;
        noc_pkg::vc_mask_t mask;
        noc_pkg::vc_mask_t gnt_n;
        noc_pkg::vc_mask_t ovc_n;
        noc_pkg::vc_mask_t rel_n;
        logic              wr;
        int                v;
        int                k;
        wr    = 1'b0;
        f     = '0;
        gnt_n = '0;
        ovc_n = '0;
        rel_n = '0;
        elig  = '0;
        v     = rnd(`NOC_V);
        if (rnd(4) != 0 && flit_q[v].size() < `NOC_B) begin
            if (tx_left[v] > 0) begin
                tx_left[v]--;
                f.tail    = (tx_left[v] == 0);
                f.payload = $random(seed);
                wr        = 1'b1;
            end else if (new_pkts && desc_q[v].size() < `NOC_MAX_PCK) begin
                tx_left[v] = 1 + rnd(3);   // packets of 2 to 4 flits
                f.hdr      = 1'b1;
                f.payload  = random_header();
                wr         = 1'b1;
            end
        end
        f.vc = noc_pkg::vc_mask_t'(1) << v;
        for (k = 0; k < `NOC_V; k++) begin
            elig[k]  = (flit_q[k].size() > 0) && !rel_pending[k];
            rel_n[k] = rel_pending[k] && (rnd(2) != 0);
        end
        if (elig != '0 && rnd(4) != 0) begin
            v = rnd(`NOC_V);
            while (!elig[v]) v = (v + 1) % `NOC_V;
            mask = class_mask(desc_q[v][0].cls);
            k = rnd(`NOC_V);
            while (!mask[k]) k = (k + 1) % `NOC_V;
            gnt_n[v] = 1'b1;
            ovc_n[k] = 1'b1;
        end
        flit_we      <= wr;
        flit_in      <= f;
        grant        <= gnt_n;
        assigned_ovc <= ovc_n;
        rel_vec      <= rel_n;
    endtask

    task automatic run_cycle(input bit new_pkts);
        @(posedge clk);
        drive_next(new_pkts);
        @(negedge clk);
        check_outputs();
        commit_model();
    endtask

    initial begin
        #(TOTAL_CYCLES * 20);
        $display("watchdog: run exceeded %0d ns without finishing", TOTAL_CYCLES * 20);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed         = 16436;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        advance_seen = 0;
        errs_before  = 0;
        dirs_seen    = '0;
        rel_pending  = '0;
        clk          = 1'b0;
        reset        = 1'b1;
        current_addr = '{x: 3'(HERE_X), y: 3'(HERE_Y)};
        flit_in      = '0;
        flit_we      = 1'b0;
        grant        = '0;
        rel_vec      = '0;
        assigned_ovc = '0;
        for (int v = 0; v < `NOC_V; v++) tx_left[v] = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare("ivc_request_o", request, '0);
        compare("ivc_tail_o", tail, '0);
        end_test("reset_state");

        repeat (TRAFFIC_CYCLES) run_cycle(1'b1);
        end_test("random_traffic");

        // finish open packets, then empty every vc
        n = 0;
        while (!model_idle() && n < DRAIN_CYCLES) begin
            run_cycle(1'b0);
            n++;
        end
        @(posedge clk);
        flit_we <= 1'b0;
        grant   <= '0;
        rel_vec <= '0;
        @(negedge clk);
        check_outputs();
        if (!model_idle()) begin
            errors++;
            $display("drain did not empty the port within %0d cycles", DRAIN_CYCLES);
        end
        end_test("drain");

        if (dirs_seen != 5'b11111) begin
            errors++;
            $display("not every output direction was routed, seen mask %b", dirs_seen);
        end
        if (advance_seen == 0) begin
            errors++;
            $display("no release ever happened with two packets queued in one vc");
        end
        end_test("coverage");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
noc_pkg.sv
fwft_fifo.sv
xy_route_decode.sv
vc_queue.sv
input_port.sv
tb_input_port.sv
